// ==== source/la_id_pkg.sv ====
package la_id_pkg;

  localparam int XLEN = 32;
  localparam int REG_ADDR_W = 5;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [31:0] inst_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  // operation handed to the execute stage.
  typedef enum logic [4:0] {
    NOP,
    ADD,
    SUB,
    SLT,
    SLTU,
    AND,
    OR,
    XOR,
    NOR,
    SLL,
    SRL,
    SRA,
    LUI,
    MUL,
    MULH,
    MULHU,
    DIV,
    MOD,
    DIVU,
    MODU
  } aluop_e;

  // result class, picks the execute result mux leg.
  typedef enum logic [2:0] {
    RES_NOP,
    RES_LOGIC,
    RES_SHIFT,
    RES_ARITH,
    RES_MOVE
  } alusel_e;

  // compared against inst[31:25].
  localparam logic [6:0] OP_LU12I_W = 7'h0a;

  // compared against inst[31:22].
  localparam logic [9:0] OP_SLTI   = 10'h008;
  localparam logic [9:0] OP_SLTUI  = 10'h009;
  localparam logic [9:0] OP_ADDI_W = 10'h00a;
  localparam logic [9:0] OP_ANDI   = 10'h00d;
  localparam logic [9:0] OP_ORI    = 10'h00e;
  localparam logic [9:0] OP_XORI   = 10'h00f;

  // compared against inst[31:15].
  localparam logic [16:0] OP_ADD_W   = 17'h00020;
  localparam logic [16:0] OP_SUB_W   = 17'h00022;
  localparam logic [16:0] OP_SLT     = 17'h00024;
  localparam logic [16:0] OP_SLTU    = 17'h00025;
  localparam logic [16:0] OP_NOR     = 17'h00028;
  localparam logic [16:0] OP_AND     = 17'h00029;
  localparam logic [16:0] OP_OR      = 17'h0002a;
  localparam logic [16:0] OP_XOR     = 17'h0002b;
  localparam logic [16:0] OP_SLL_W   = 17'h0002e;
  localparam logic [16:0] OP_SRL_W   = 17'h0002f;
  localparam logic [16:0] OP_SRA_W   = 17'h00030;
  localparam logic [16:0] OP_MUL_W   = 17'h00038;
  localparam logic [16:0] OP_MULH_W  = 17'h00039;
  localparam logic [16:0] OP_MULH_WU = 17'h0003a;
  localparam logic [16:0] OP_DIV_W   = 17'h00040;
  localparam logic [16:0] OP_MOD_W   = 17'h00041;
  localparam logic [16:0] OP_DIV_WU  = 17'h00042;
  localparam logic [16:0] OP_MOD_WU  = 17'h00043;
  localparam logic [16:0] OP_SLLI_W  = 17'h00081;
  localparam logic [16:0] OP_SRLI_W  = 17'h00089;
  localparam logic [16:0] OP_SRAI_W  = 17'h00091;

  // r0 is hardwired to zero.
  function automatic logic is_zero_reg(input reg_addr_t addr);
    return addr == '0;
  endfunction

endpackage

// ==== source/inst_decoder.sv ====
`timescale 1ns/100ps

module inst_decoder (
  input  la_id_pkg::inst_t     inst_i,
  output la_id_pkg::aluop_e    aluop_o,
  output la_id_pkg::alusel_e   alusel_o,
  output logic                 rj_read_o,
  output logic                 rk_read_o,
  output la_id_pkg::reg_addr_t rj_addr_o,
  output la_id_pkg::reg_addr_t rk_addr_o,
  output la_id_pkg::reg_addr_t waddr_o,
  output logic                 wreg_o,
  output la_id_pkg::word_t     imm_o,
  output logic                 inst_valid_o
);

  logic [16:0] opcode_17;
  logic [9:0]  opcode_10;
  logic [6:0]  opcode_7;
  logic [4:0]  ui5;
  logic [11:0] i12;
  logic [19:0] si20;

  la_id_pkg::aluop_e op17;
  la_id_pkg::aluop_e op10;
  logic              shift_imm;
  logic              sext_imm;
  logic              lui_hit;

  assign opcode_17 = inst_i[31:15];
  assign opcode_10 = inst_i[31:22];
  assign opcode_7  = inst_i[31:25];
  assign ui5       = inst_i[14:10];
  assign i12       = inst_i[21:10];
  assign si20      = inst_i[24:5];

  function automatic la_id_pkg::alusel_e sel_of(input la_id_pkg::aluop_e op);
    case (op)
      la_id_pkg::NOP: return la_id_pkg::RES_NOP;
      la_id_pkg::AND,
      la_id_pkg::OR,
      la_id_pkg::XOR,
      la_id_pkg::NOR: return la_id_pkg::RES_LOGIC;
      la_id_pkg::SLL,
      la_id_pkg::SRL,
      la_id_pkg::SRA: return la_id_pkg::RES_SHIFT;
      la_id_pkg::LUI: return la_id_pkg::RES_MOVE;
      default: return la_id_pkg::RES_ARITH;
    endcase
  endfunction

  // 17-bit prefixes, register-register and shift-immediate.
  always_comb
  begin
    case (opcode_17)
      la_id_pkg::OP_ADD_W:   op17 = la_id_pkg::ADD;
      la_id_pkg::OP_SUB_W:   op17 = la_id_pkg::SUB;
      la_id_pkg::OP_SLT:     op17 = la_id_pkg::SLT;
      la_id_pkg::OP_SLTU:    op17 = la_id_pkg::SLTU;
      la_id_pkg::OP_NOR:     op17 = la_id_pkg::NOR;
      la_id_pkg::OP_AND:     op17 = la_id_pkg::AND;
      la_id_pkg::OP_OR:      op17 = la_id_pkg::OR;
      la_id_pkg::OP_XOR:     op17 = la_id_pkg::XOR;
      la_id_pkg::OP_SLL_W:   op17 = la_id_pkg::SLL;
      la_id_pkg::OP_SRL_W:   op17 = la_id_pkg::SRL;
      la_id_pkg::OP_SRA_W:   op17 = la_id_pkg::SRA;
      la_id_pkg::OP_MUL_W:   op17 = la_id_pkg::MUL;
      la_id_pkg::OP_MULH_W:  op17 = la_id_pkg::MULH;
      la_id_pkg::OP_MULH_WU: op17 = la_id_pkg::MULHU;
      la_id_pkg::OP_DIV_W:   op17 = la_id_pkg::DIV;
      la_id_pkg::OP_MOD_W:   op17 = la_id_pkg::MOD;
      la_id_pkg::OP_DIV_WU:  op17 = la_id_pkg::DIVU;
      la_id_pkg::OP_MOD_WU:  op17 = la_id_pkg::MODU;
      la_id_pkg::OP_SLLI_W:  op17 = la_id_pkg::SLL;
      la_id_pkg::OP_SRLI_W:  op17 = la_id_pkg::SRL;
      la_id_pkg::OP_SRAI_W:  op17 = la_id_pkg::SRA;
      default:               op17 = la_id_pkg::NOP;
    endcase
  end

  assign shift_imm = opcode_17 inside {la_id_pkg::OP_SLLI_W, la_id_pkg::OP_SRLI_W,
                                       la_id_pkg::OP_SRAI_W};

  // 10-bit prefixes, 12-bit immediate group.
  always_comb
  begin
    case (opcode_10)
      la_id_pkg::OP_SLTI:   op10 = la_id_pkg::SLT;
      la_id_pkg::OP_SLTUI:  op10 = la_id_pkg::SLTU;
      la_id_pkg::OP_ADDI_W: op10 = la_id_pkg::ADD;
      la_id_pkg::OP_ANDI:   op10 = la_id_pkg::AND;
      la_id_pkg::OP_ORI:    op10 = la_id_pkg::OR;
      la_id_pkg::OP_XORI:   op10 = la_id_pkg::XOR;
      default:              op10 = la_id_pkg::NOP;
    endcase
  end

  assign sext_imm = opcode_10 inside {la_id_pkg::OP_SLTI, la_id_pkg::OP_SLTUI,
                                      la_id_pkg::OP_ADDI_W};
  assign lui_hit  = opcode_7 == la_id_pkg::OP_LU12I_W;

  // longest prefix wins.
  always_comb
  begin
    aluop_o   = la_id_pkg::NOP;
    rj_read_o = 1'b0;
    rk_read_o = 1'b0;
    imm_o     = '0;
    if (op17 != la_id_pkg::NOP)
    begin
      aluop_o   = op17;
      rj_read_o = 1'b1;
      rk_read_o = !shift_imm;
      if (shift_imm)
        imm_o = {27'b0, ui5}; // shift amount.
    end
    else if (op10 != la_id_pkg::NOP)
    begin
      aluop_o   = op10;
      rj_read_o = 1'b1;
      if (sext_imm)
        imm_o = {{20{i12[11]}}, i12};
      else
        imm_o = {20'b0, i12}; // logic ops zero-extend.
    end
    else if (lui_hit)
    begin
      aluop_o = la_id_pkg::LUI;
      imm_o   = {si20, 12'b0};
    end
  end

  assign alusel_o     = sel_of(aluop_o);
  assign inst_valid_o = aluop_o != la_id_pkg::NOP;
  assign wreg_o       = inst_valid_o;
  assign rj_addr_o    = inst_i[9:5];
  assign rk_addr_o    = inst_i[14:10];
  assign waddr_o      = inst_valid_o ? inst_i[4:0] : '0;

endmodule

// ==== source/operand_forward.sv ====
`timescale 1ns/100ps

module operand_forward (
  input  logic                 read_i,
  input  la_id_pkg::reg_addr_t addr_i,
  input  logic                 ex_wreg_i,
  input  la_id_pkg::reg_addr_t ex_waddr_i,
  input  la_id_pkg::word_t     ex_wdata_i,
  input  logic                 mem_wreg_i,
  input  la_id_pkg::reg_addr_t mem_waddr_i,
  input  la_id_pkg::word_t     mem_wdata_i,
  input  la_id_pkg::word_t     rf_data_i,
  input  la_id_pkg::word_t     imm_i,
  output la_id_pkg::word_t     operand_o
);

  logic ex_hit;
  logic mem_hit;

  assign ex_hit  = ex_wreg_i && (ex_waddr_i == addr_i);
  assign mem_hit = mem_wreg_i && (mem_waddr_i == addr_i);

  always_comb
  begin
    if (!read_i)
      operand_o = imm_i;
    else if (la_id_pkg::is_zero_reg(addr_i))
      operand_o = '0; // r0 never forwarded.
    else if (ex_hit)
      operand_o = ex_wdata_i; // youngest result first.
    else if (mem_hit)
      operand_o = mem_wdata_i;
    else
      operand_o = rf_data_i;
  end

endmodule

// ==== source/reg_file.sv ====
`timescale 1ns/100ps

module reg_file (
  input  logic                 clk,
  input  logic                 rst_n_i,
  input  la_id_pkg::reg_addr_t raddr_a_i,
  input  la_id_pkg::reg_addr_t raddr_b_i,
  output la_id_pkg::word_t     rdata_a_o,
  output la_id_pkg::word_t     rdata_b_o,
  input  logic                 wb_we_i,
  input  la_id_pkg::reg_addr_t wb_waddr_i,
  input  la_id_pkg::word_t     wb_wdata_i
);

  la_id_pkg::word_t regs [32];

  logic wr_en;

  assign wr_en = wb_we_i && !la_id_pkg::is_zero_reg(wb_waddr_i);

  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
    begin
      for (int i = 0; i < 32; i++)
        regs[i] <= '0;
    end
    else if (wr_en)
      regs[wb_waddr_i] <= wb_wdata_i;
  end

  // same-cycle write is bypassed to the read.
  always_comb
  begin
    if (la_id_pkg::is_zero_reg(raddr_a_i))
      rdata_a_o = '0;
    else if (wr_en && (wb_waddr_i == raddr_a_i))
      rdata_a_o = wb_wdata_i;
    else
      rdata_a_o = regs[raddr_a_i];

    if (la_id_pkg::is_zero_reg(raddr_b_i))
      rdata_b_o = '0;
    else if (wr_en && (wb_waddr_i == raddr_b_i))
      rdata_b_o = wb_wdata_i;
    else
      rdata_b_o = regs[raddr_b_i];
  end

endmodule

// ==== source/id_ex_reg.sv ====
`timescale 1ns/100ps

module id_ex_reg #(
  parameter la_id_pkg::word_t RESET_PC = 32'h1c00_0000
) (
  input  logic                 clk,
  input  logic                 rst_n_i,
  input  la_id_pkg::aluop_e    aluop_i,
  input  la_id_pkg::alusel_e   alusel_i,
  input  la_id_pkg::word_t     opa_i,
  input  la_id_pkg::word_t     opb_i,
  input  la_id_pkg::reg_addr_t waddr_i,
  input  logic                 wreg_i,
  input  logic                 inst_valid_i,
  input  la_id_pkg::word_t     pc_i,
  output la_id_pkg::aluop_e    ex_aluop_o,
  output la_id_pkg::alusel_e   ex_alusel_o,
  output la_id_pkg::word_t     ex_opa_o,
  output la_id_pkg::word_t     ex_opb_o,
  output la_id_pkg::reg_addr_t ex_waddr_o,
  output logic                 ex_wreg_o,
  output logic                 ex_inst_valid_o,
  output la_id_pkg::word_t     ex_pc_o
);

  // loads every cycle, no stall.
  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
    begin
      ex_aluop_o      <= la_id_pkg::NOP;
      ex_alusel_o     <= la_id_pkg::RES_NOP;
      ex_opa_o        <= '0;
      ex_opb_o        <= '0;
      ex_waddr_o      <= '0;
      ex_wreg_o       <= 1'b0;
      ex_inst_valid_o <= 1'b0;
      ex_pc_o         <= RESET_PC;
    end
    else
    begin
      ex_aluop_o      <= aluop_i;
      ex_alusel_o     <= alusel_i;
      ex_opa_o        <= opa_i;
      ex_opb_o        <= opb_i;
      ex_waddr_o      <= waddr_i;
      ex_wreg_o       <= wreg_i;
      ex_inst_valid_o <= inst_valid_i;
      ex_pc_o         <= pc_i;
    end
  end

endmodule

// ==== source/id_stage.sv ====
`timescale 1ns/100ps

module id_stage #(
  parameter la_id_pkg::word_t RESET_PC = 32'h1c00_0000
) (
  input  logic                 clk,
  input  logic                 rst_n_i,
  input  la_id_pkg::word_t     pc_i,
  input  la_id_pkg::inst_t     inst_i,
  input  logic                 ex_wreg_i,
  input  la_id_pkg::reg_addr_t ex_waddr_i,
  input  la_id_pkg::word_t     ex_wdata_i,
  input  logic                 mem_wreg_i,
  input  la_id_pkg::reg_addr_t mem_waddr_i,
  input  la_id_pkg::word_t     mem_wdata_i,
  input  logic                 wb_we_i,
  input  la_id_pkg::reg_addr_t wb_waddr_i,
  input  la_id_pkg::word_t     wb_wdata_i,
  output la_id_pkg::aluop_e    ex_aluop_o,
  output la_id_pkg::alusel_e   ex_alusel_o,
  output la_id_pkg::word_t     ex_opa_o,
  output la_id_pkg::word_t     ex_opb_o,
  output la_id_pkg::reg_addr_t ex_waddr_o,
  output logic                 ex_wreg_o,
  output logic                 ex_inst_valid_o,
  output la_id_pkg::word_t     ex_pc_o
);

  la_id_pkg::aluop_e    aluop;
  la_id_pkg::alusel_e   alusel;
  logic                 rj_read;
  logic                 rk_read;
  la_id_pkg::reg_addr_t rj_addr;
  la_id_pkg::reg_addr_t rk_addr;
  la_id_pkg::reg_addr_t waddr;
  logic                 wreg;
  la_id_pkg::word_t     imm;
  logic                 inst_valid;
  la_id_pkg::word_t     rj_data;
  la_id_pkg::word_t     rk_data;
  la_id_pkg::word_t     opa;
  la_id_pkg::word_t     opb;

  inst_decoder inst_decoder_inst (
    .inst_i       (inst_i),
    .aluop_o      (aluop),
    .alusel_o     (alusel),
    .rj_read_o    (rj_read),
    .rk_read_o    (rk_read),
    .rj_addr_o    (rj_addr),
    .rk_addr_o    (rk_addr),
    .waddr_o      (waddr),
    .wreg_o       (wreg),
    .imm_o        (imm),
    .inst_valid_o (inst_valid)
  );

  reg_file reg_file_inst (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .raddr_a_i  (rj_addr),
    .raddr_b_i  (rk_addr),
    .rdata_a_o  (rj_data),
    .rdata_b_o  (rk_data),
    .wb_we_i    (wb_we_i),
    .wb_waddr_i (wb_waddr_i),
    .wb_wdata_i (wb_wdata_i)
  );

  // operand a has no immediate, lu12i.w gets zero.
  operand_forward opa_fwd_inst (
    .read_i      (rj_read),
    .addr_i      (rj_addr),
    .ex_wreg_i   (ex_wreg_i),
    .ex_waddr_i  (ex_waddr_i),
    .ex_wdata_i  (ex_wdata_i),
    .mem_wreg_i  (mem_wreg_i),
    .mem_waddr_i (mem_waddr_i),
    .mem_wdata_i (mem_wdata_i),
    .rf_data_i   (rj_data),
    .imm_i       ('0),
    .operand_o   (opa)
  );

  operand_forward opb_fwd_inst (
    .read_i      (rk_read),
    .addr_i      (rk_addr),
    .ex_wreg_i   (ex_wreg_i),
    .ex_waddr_i  (ex_waddr_i),
    .ex_wdata_i  (ex_wdata_i),
    .mem_wreg_i  (mem_wreg_i),
    .mem_waddr_i (mem_waddr_i),
    .mem_wdata_i (mem_wdata_i),
    .rf_data_i   (rk_data),
    .imm_i       (imm),
    .operand_o   (opb)
  );

  id_ex_reg #(
    .RESET_PC (RESET_PC)
  ) id_ex_reg_inst (
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .aluop_i         (aluop),
    .alusel_i        (alusel),
    .opa_i           (opa),
    .opb_i           (opb),
    .waddr_i         (waddr),
    .wreg_i          (wreg),
    .inst_valid_i    (inst_valid),
    .pc_i            (pc_i),
    .ex_aluop_o      (ex_aluop_o),
    .ex_alusel_o     (ex_alusel_o),
    .ex_opa_o        (ex_opa_o),
    .ex_opb_o        (ex_opb_o),
    .ex_waddr_o      (ex_waddr_o),
    .ex_wreg_o       (ex_wreg_o),
    .ex_inst_valid_o (ex_inst_valid_o),
    .ex_pc_o         (ex_pc_o)
  );

endmodule

// ==== test/tb_id_stage.sv ====
`timescale 1ns/100ps

module tb_id_stage;

  localparam la_id_pkg::word_t RESET_PC = 32'h1c00_0000;

  logic                 clk;
  logic                 rst_n_i;
  la_id_pkg::word_t     pc_i;
  la_id_pkg::inst_t     inst_i;
  logic                 ex_wreg_i;
  la_id_pkg::reg_addr_t ex_waddr_i;
  la_id_pkg::word_t     ex_wdata_i;
  logic                 mem_wreg_i;
  la_id_pkg::reg_addr_t mem_waddr_i;
  la_id_pkg::word_t     mem_wdata_i;
  logic                 wb_we_i;
  la_id_pkg::reg_addr_t wb_waddr_i;
  la_id_pkg::word_t     wb_wdata_i;
  la_id_pkg::aluop_e    ex_aluop_o;
  la_id_pkg::alusel_e   ex_alusel_o;
  la_id_pkg::word_t     ex_opa_o;
  la_id_pkg::word_t     ex_opb_o;
  la_id_pkg::reg_addr_t ex_waddr_o;
  logic                 ex_wreg_o;
  logic                 ex_inst_valid_o;
  la_id_pkg::word_t     ex_pc_o;

  la_id_pkg::word_t     shadow [32]; // mirror of the register file.
  la_id_pkg::aluop_e    exp_op;
  la_id_pkg::alusel_e   exp_sel;
  la_id_pkg::word_t     exp_opa;
  la_id_pkg::word_t     exp_opb;
  la_id_pkg::word_t     exp_pc;
  la_id_pkg::reg_addr_t exp_waddr;
  logic                 exp_valid;
  string                test_name;
  int                   test_errors;
  int                   errors = 0;
  int                   checks = 0;
  int                   cycles = 0;
  int unsigned          seed;
  int unsigned          dummy;

  id_stage #(
    .RESET_PC (RESET_PC)
  ) id_stage_inst (
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .pc_i            (pc_i),
    .inst_i          (inst_i),
    .ex_wreg_i       (ex_wreg_i),
    .ex_waddr_i      (ex_waddr_i),
    .ex_wdata_i      (ex_wdata_i),
    .mem_wreg_i      (mem_wreg_i),
    .mem_waddr_i     (mem_waddr_i),
    .mem_wdata_i     (mem_wdata_i),
    .wb_we_i         (wb_we_i),
    .wb_waddr_i      (wb_waddr_i),
    .wb_wdata_i      (wb_wdata_i),
    .ex_aluop_o      (ex_aluop_o),
    .ex_alusel_o     (ex_alusel_o),
    .ex_opa_o        (ex_opa_o),
    .ex_opb_o        (ex_opb_o),
    .ex_waddr_o      (ex_waddr_o),
    .ex_wreg_o       (ex_wreg_o),
    .ex_inst_valid_o (ex_inst_valid_o),
    .ex_pc_o         (ex_pc_o)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk)
    cycles <= cycles + 1;

  // returns 2 ns after the next rising edge.
  task automatic next_cycle();
    int start;
    int guard;
    start = cycles;
    guard = 0;
    #0.5;
    while (cycles == start && guard < 100)
    begin
      #1;
      guard++;
    end
    if (cycles == start)
    begin
      $display("timeout: no rising clock edge seen within 100 ns");
      $display("Simulation FAILED");
      $finish;
    end
    else
      #1.5;
  endtask

  task automatic report(input logic ok, input string what, input string exp, input string act);
    checks++;
    if (!ok)
    begin
      errors++;
      test_errors++;
      $display("ERR %s %s expected %s actual %s", test_name, what, exp, act);
    end
  endtask

  task automatic check_word(input string what, input la_id_pkg::word_t exp, act);
    report(exp === act, what, $sformatf("%h", exp), $sformatf("%h", act));
  endtask

  task automatic check_op(input string what, input la_id_pkg::aluop_e exp, act);
    report(exp === act, what, exp.name(), $sformatf("%s(%0d)", act.name(), act));
  endtask

  task automatic check_sel(input string what, input la_id_pkg::alusel_e exp, act);
    report(exp === act, what, exp.name(), $sformatf("%s(%0d)", act.name(), act));
  endtask

  task automatic check_addr(input string what, input la_id_pkg::reg_addr_t exp, act);
    report(exp === act, what, $sformatf("%0d", exp), $sformatf("%0d", act));
  endtask

  task automatic check_bit(input string what, input logic exp, act);
    report(exp === act, what, $sformatf("%b", exp), $sformatf("%b", act));
  endtask

  // idx 0..17 reg-reg, 18..23 imm12, 24..26 shift imm, 27 lu12i.w.
  function automatic la_id_pkg::inst_t encode(input int idx, input la_id_pkg::reg_addr_t rd,
                                              input la_id_pkg::reg_addr_t rj,
                                              input la_id_pkg::reg_addr_t rk,
                                              input logic [19:0] imm);
    logic [16:0] p17;
    p17 = '0;
    case (idx)
      0: p17 = la_id_pkg::OP_ADD_W;
      1: p17 = la_id_pkg::OP_SUB_W;
      2: p17 = la_id_pkg::OP_SLT;
      3: p17 = la_id_pkg::OP_SLTU;
      4: p17 = la_id_pkg::OP_NOR;
      5: p17 = la_id_pkg::OP_AND;
      6: p17 = la_id_pkg::OP_OR;
      7: p17 = la_id_pkg::OP_XOR;
      8: p17 = la_id_pkg::OP_SLL_W;
      9: p17 = la_id_pkg::OP_SRL_W;
      10: p17 = la_id_pkg::OP_SRA_W;
      11: p17 = la_id_pkg::OP_MUL_W;
      12: p17 = la_id_pkg::OP_MULH_W;
      13: p17 = la_id_pkg::OP_MULH_WU;
      14: p17 = la_id_pkg::OP_DIV_W;
      15: p17 = la_id_pkg::OP_MOD_W;
      16: p17 = la_id_pkg::OP_DIV_WU;
      17: p17 = la_id_pkg::OP_MOD_WU;
      18: return {la_id_pkg::OP_SLTI, imm[11:0], rj, rd};
      19: return {la_id_pkg::OP_SLTUI, imm[11:0], rj, rd};
      20: return {la_id_pkg::OP_ADDI_W, imm[11:0], rj, rd};
      21: return {la_id_pkg::OP_ANDI, imm[11:0], rj, rd};
      22: return {la_id_pkg::OP_ORI, imm[11:0], rj, rd};
      23: return {la_id_pkg::OP_XORI, imm[11:0], rj, rd};
      24: p17 = la_id_pkg::OP_SLLI_W;
      25: p17 = la_id_pkg::OP_SRLI_W;
      26: p17 = la_id_pkg::OP_SRAI_W;
      27: return {la_id_pkg::OP_LU12I_W, imm, rd};
      default: return 32'h0;
    endcase
    if (idx >= 24)
      return {p17, imm[4:0], rj, rd};
    return {p17, rk, rj, rd};
  endfunction

  function automatic la_id_pkg::aluop_e op_of(input int idx);
    case (idx)
      0, 20: return la_id_pkg::ADD;
      1: return la_id_pkg::SUB;
      2, 18: return la_id_pkg::SLT;
      3, 19: return la_id_pkg::SLTU;
      4: return la_id_pkg::NOR;
      5, 21: return la_id_pkg::AND;
      6, 22: return la_id_pkg::OR;
      7, 23: return la_id_pkg::XOR;
      8, 24: return la_id_pkg::SLL;
      9, 25: return la_id_pkg::SRL;
      10, 26: return la_id_pkg::SRA;
      11: return la_id_pkg::MUL;
      12: return la_id_pkg::MULH;
      13: return la_id_pkg::MULHU;
      14: return la_id_pkg::DIV;
      15: return la_id_pkg::MOD;
      16: return la_id_pkg::DIVU;
      17: return la_id_pkg::MODU;
      27: return la_id_pkg::LUI;
      default: return la_id_pkg::NOP;
    endcase
  endfunction

  function automatic la_id_pkg::alusel_e sel_for(input int idx);
    case (idx)
      4, 5, 6, 7, 21, 22, 23: return la_id_pkg::RES_LOGIC;
      8, 9, 10, 24, 25, 26: return la_id_pkg::RES_SHIFT;
      27: return la_id_pkg::RES_MOVE;
      default: return la_id_pkg::RES_ARITH;
    endcase
  endfunction

  function automatic la_id_pkg::word_t imm_of(input int idx, input logic [19:0] imm);
    if (idx <= 20)
      return {{20{imm[11]}}, imm[11:0]}; // slti, sltui, addi.w.
    if (idx <= 23)
      return {20'h0, imm[11:0]};
    if (idx <= 26)
      return {27'h0, imm[4:0]};
    return {imm, 12'h0};
  endfunction

  function automatic la_id_pkg::word_t fwd_value(input la_id_pkg::reg_addr_t addr);
    if (addr == 5'd0)
      return '0;
    if (ex_wreg_i && ex_waddr_i == addr)
      return ex_wdata_i;
    if (mem_wreg_i && mem_waddr_i == addr)
      return mem_wdata_i;
    if (wb_we_i && wb_waddr_i == addr)
      return wb_wdata_i; // write-back landing this cycle.
    return shadow[addr];
  endfunction

  function automatic la_id_pkg::reg_addr_t rand_reg();
    return la_id_pkg::reg_addr_t'($urandom % 32);
  endfunction

  task automatic expect_nop(input la_id_pkg::word_t pc);
    exp_valid = 1'b0;
    exp_op    = la_id_pkg::NOP;
    exp_sel   = la_id_pkg::RES_NOP;
    exp_opa   = '0;
    exp_opb   = '0;
    exp_pc    = pc;
  endtask

  // drives one instruction and records its expected ID/EX contents.
  task automatic issue(input int idx, input la_id_pkg::reg_addr_t rd, rj, rk,
                       input logic [19:0] imm);
    inst_i    = encode(idx, rd, rj, rk, imm);
    pc_i      = $urandom;
    exp_valid = 1'b1;
    exp_op    = op_of(idx);
    exp_sel   = sel_for(idx);
    exp_waddr = rd;
    exp_pc    = pc_i;
    exp_opa   = (idx == 27) ? '0 : fwd_value(rj);
    exp_opb   = (idx < 18) ? fwd_value(rk) : imm_of(idx, imm);
  endtask

  task automatic issue_raw(input la_id_pkg::inst_t word);
    inst_i = word;
    pc_i   = $urandom;
    expect_nop(pc_i);
  endtask

  task automatic verify_outputs();
    check_op("aluop", exp_op, ex_aluop_o);
    check_sel("alusel", exp_sel, ex_alusel_o);
    check_word("opa", exp_opa, ex_opa_o);
    check_word("opb", exp_opb, ex_opb_o);
    check_bit("wreg", exp_valid, ex_wreg_o);
    check_bit("valid", exp_valid, ex_inst_valid_o);
    check_word("pc", exp_pc, ex_pc_o);
    if (exp_valid)
      check_addr("waddr", exp_waddr, ex_waddr_o);
  endtask

  task automatic wb_write(input la_id_pkg::reg_addr_t addr, input la_id_pkg::word_t data);
    wb_we_i    = 1'b1;
    wb_waddr_i = addr;
    wb_wdata_i = data;
    inst_i     = '0;
    next_cycle();
    wb_we_i = 1'b0;
    if (addr != 5'd0)
      shadow[addr] = data;
  endtask

  task automatic set_fwd(input logic ex_we, input la_id_pkg::reg_addr_t ex_a,
                         input la_id_pkg::word_t ex_d, input logic mem_we,
                         input la_id_pkg::reg_addr_t mem_a, input la_id_pkg::word_t mem_d);
    ex_wreg_i   = ex_we;
    ex_waddr_i  = ex_a;
    ex_wdata_i  = ex_d;
    mem_wreg_i  = mem_we;
    mem_waddr_i = mem_a;
    mem_wdata_i = mem_d;
  endtask

  task automatic end_test();
    $display("test %-10s done, %0d mismatches", test_name, test_errors);
  endtask

  task automatic reset_seq();
    test_name   = "reset";
    test_errors = 0;
    rst_n_i     = 1'b0;
    issue(0, 5'd3, 5'd1, 5'd2, 20'h0); // must not get through reset.
    expect_nop(RESET_PC);
    for (int i = 0; i < 5; i++)
    begin
      next_cycle();
      verify_outputs();
    end
    rst_n_i = 1'b1;
    end_test();
  endtask

  task automatic reg_reg_group();
    test_name   = "reg_reg";
    test_errors = 0;
    for (int r = 1; r < 32; r++)
      wb_write(la_id_pkg::reg_addr_t'(r), $urandom);
    for (int i = 0; i < 18; i++)
    begin
      issue(i, rand_reg(), rand_reg(), rand_reg(), 20'h0);
      next_cycle();
      verify_outputs();
    end
    // write-back and read of one register in the same cycle.
    wb_we_i    = 1'b1;
    wb_waddr_i = 5'd4;
    wb_wdata_i = $urandom;
    issue(0, 5'd8, 5'd4, 5'd11, 20'h0);
    next_cycle();
    wb_we_i   = 1'b0;
    shadow[4] = wb_wdata_i;
    verify_outputs();
    end_test();
  endtask

  task automatic imm_groups();
    logic [19:0] imm;
    test_name   = "imm";
    test_errors = 0;
    for (int i = 18; i < 28; i++)
    begin
      imm = 20'($urandom) | 20'h80810; // top bit of every field set.
      issue(i, rand_reg(), rand_reg(), rand_reg(), imm);
      next_cycle();
      verify_outputs();
    end
    end_test();
  endtask

  task automatic forward_paths();
    test_name   = "forward";
    test_errors = 0;
    set_fwd(1'b1, 5'd5, 32'haaaa_0001, 1'b1, 5'd5, 32'hbbbb_0002);
    issue(0, 5'd9, 5'd5, 5'd6, 20'h0);
    next_cycle();
    verify_outputs();
    check_word("ex over mem", 32'haaaa_0001, ex_opa_o);
    set_fwd(1'b1, 5'd7, 32'haaaa_0003, 1'b1, 5'd6, 32'hbbbb_0004);
    issue(0, 5'd9, 5'd5, 5'd6, 20'h0);
    next_cycle();
    verify_outputs();
    check_word("mem only", 32'hbbbb_0004, ex_opb_o);
    set_fwd(1'b0, 5'd5, 32'haaaa_0005, 1'b0, 5'd6, 32'hbbbb_0006);
    issue(0, 5'd9, 5'd5, 5'd6, 20'h0);
    next_cycle();
    verify_outputs();
    check_word("wreg low", shadow[5], ex_opa_o);
    set_fwd(1'b1, 5'd0, 32'haaaa_0007, 1'b1, 5'd0, 32'hbbbb_0008);
    issue(0, 5'd9, 5'd0, 5'd0, 20'h0);
    next_cycle();
    verify_outputs();
    check_word("r0", 32'h0, ex_opa_o);
    set_fwd(1'b0, 5'd0, 32'h0, 1'b0, 5'd0, 32'h0);
    end_test();
  endtask

  task automatic invalid_words();
    test_name   = "invalid";
    test_errors = 0;
    issue_raw(32'h5800_0c41); // beq.
    next_cycle();
    verify_outputs();
    issue_raw(32'h2880_0c41); // ld.w.
    next_cycle();
    verify_outputs();
    end_test();
  endtask

  task automatic random_stream();
    la_id_pkg::reg_addr_t rj;
    la_id_pkg::reg_addr_t rk;
    test_name   = "stream";
    test_errors = 0;
    for (int n = 0; n < 40; n++)
    begin
      rj = rand_reg();
      rk = rand_reg();
      set_fwd($urandom % 2, ($urandom % 2) ? rj : rand_reg(), $urandom,
              $urandom % 2, ($urandom % 2) ? rk : rand_reg(), $urandom);
      issue($urandom % 28, rand_reg(), rj, rk, 20'($urandom));
      next_cycle();
      verify_outputs();
    end
    set_fwd(1'b0, 5'd0, 32'h0, 1'b0, 5'd0, 32'h0);
    end_test();
  endtask

  initial
  begin
    seed  = 32'hca1a_33db;
    dummy = $urandom(seed);
    rst_n_i = 1'b0;
    pc_i    = '0;
    inst_i  = '0;
    wb_we_i    = 1'b0;
    wb_waddr_i = '0;
    wb_wdata_i = '0;
    set_fwd(1'b0, 5'd0, 32'h0, 1'b0, 5'd0, 32'h0);
    for (int r = 0; r < 32; r++)
      shadow[r] = '0;
    reset_seq();
    reg_reg_group();
    imm_groups();
    forward_paths();
    invalid_words();
    random_stream();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

// ==== compile.f ====
source/la_id_pkg.sv
source/inst_decoder.sv
source/operand_forward.sv
source/reg_file.sv
source/id_ex_reg.sv
source/id_stage.sv
test/tb_id_stage.sv
